// ==== dtim.f ====
+incdir+include
design/dtim_pkg.sv
design/dtim_front_if.sv
design/dtim_bank_if.sv
design/dtim_ram.sv
design/dtim_bank_array.sv
design/dtim_front.sv
design/dtim_ctrl.sv
design/dtim.sv
verif/dtim_backing_mem.sv
verif/dtim_tb.sv

// ==== Makefile ====
# Verilator build of the DTIM testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module dtim_tb -f dtim.f --Mdir obj_dir -o dtim_sim

run: compile
	./obj_dir/dtim_sim | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/dtim_tb.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_tb;

  localparam int num_directed = 13;
  localparam int num_random = 300;
  localparam int max_random_fences = 8;
  localparam int num_ops = num_directed + num_random;
  localparam int num_fences = 1 + max_random_fences;
  localparam int timeout_cycles = num_ops * 8 + num_fences * 64 * 6;

  localparam int kind_hit = 0;
  localparam int kind_miss = 1;
  localparam int kind_direct = 2;
  localparam int kind_fence = 3;

  logic clock = 1'b0;
  logic reset;
  logic mem_valid;
  logic mem_fence;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wstrb;
  logic [31:0] mem_rdata;
  logic mem_ready;
  logic dmem_valid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0] dmem_wstrb;
  logic [31:0] dmem_rdata;
  logic dmem_ready;

  // Model of the 64 slots and of backing memory.
  logic slot_lock [64] = '{default: '0};
  logic slot_dirty [64] = '{default: '0};
  logic [23:0] slot_tag [64] = '{default: '0};
  logic [31:0] slot_data [64] = '{default: '0};
  logic [31:0] shadow [1024];

  logic [31:0] tx_addr [$];
  logic [31:0] tx_data [$];
  logic [3:0] tx_strb [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0] exp_strb [$];

  int checks = 0;
  int errors = 0;
  int cycles = 0;

  dtim dtim_i (
    .clock (clock),
    .reset (reset),
    .mem_valid (mem_valid),
    .mem_fence (mem_fence),
    .mem_addr (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .dmem_valid (dmem_valid),
    .dmem_addr (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

  dtim_backing_mem backing_i (
    .clock (clock),
    .reset (reset),
    .dmem_valid (dmem_valid),
    .dmem_addr (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

  always #5 clock = ~clock;

  // ====================
  // Monitors
  // ====================
  always @(negedge clock) begin
    if (dmem_valid && dmem_ready) begin
      tx_addr.push_back(dmem_addr); // Accepted request.
      tx_data.push_back(dmem_wdata);
      tx_strb.push_back(dmem_wstrb);
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("Timeout: mem_ready did not arrive within %0d cycles", timeout_cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic expect_request(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_strb.push_back(strb);
  endtask

  // ====================
  // One core request
  // ====================
  task automatic run_op(input logic fence, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] strb);
    int kind;
    int n;
    logic [5:0] slot;
    logic [9:0] idx;
    logic [31:0] exp_rdata;
    logic check_rdata;
    logic [31:0] got_rdata;
    slot = addr[7:2];
    idx = addr[11:2];
    exp_rdata = '0;
    check_rdata = 1'b0;
    exp_addr.delete();
    exp_data.delete();
    exp_strb.delete();
    tx_addr.delete();
    tx_data.delete();
    tx_strb.delete();
    if (fence) begin
      kind = kind_fence;
      for (int i = 0; i < 64; i++) begin
        if (slot_lock[i] && slot_dirty[i]) begin
          expect_request({slot_tag[i], i[5:0], 2'b00}, slot_data[i], 4'hf);
          shadow[{slot_tag[i][3:0], i[5:0]}] = slot_data[i];
        end
        slot_lock[i] = 1'b0;
        slot_dirty[i] = 1'b0;
        slot_tag[i] = '0;
        slot_data[i] = '0;
      end
    end else if (addr < `DTIM_BASE_ADDR || addr >= `DTIM_TOP_ADDR ||
                 (slot_lock[slot] && slot_tag[slot] != addr[31:8])) begin
      kind = kind_direct;
      expect_request({addr[31:2], 2'b00}, (strb != 4'h0) ? wdata : 32'h0, strb);
      check_rdata = (strb == 4'h0);
      exp_rdata = shadow[idx];
      shadow[idx] = apply_strobes(shadow[idx], wdata, strb);
    end else if (!slot_lock[slot]) begin
      kind = kind_miss;
      expect_request({addr[31:2], 2'b00}, 32'h0, 4'h0); // Fetch only.
      check_rdata = (strb == 4'h0);
      exp_rdata = shadow[idx];
      if (strb != 4'h0) begin
        slot_lock[slot] = 1'b1;
        slot_dirty[slot] = 1'b1;
        slot_tag[slot] = addr[31:8];
        slot_data[slot] = apply_strobes(shadow[idx], wdata, strb);
      end
    end else begin
      kind = kind_hit;
      check_rdata = 1'b1;
      exp_rdata = (strb == 4'h0) ? slot_data[slot] : 32'h0;
      if (strb != 4'h0) begin
        slot_data[slot] = apply_strobes(slot_data[slot], wdata, strb);
        slot_dirty[slot] = 1'b1;
      end
    end

    @(posedge clock);
    #1;
    mem_valid = 1'b1;
    mem_fence = fence;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = strb;
    @(negedge clock);
    compare_value(32'(mem_ready), 0, "mem_ready before request");
    compare_value(32'(dmem_valid), 0, "dmem_valid before request");
    @(posedge clock);
    #1;
    mem_valid = 1'b0;
    mem_fence = 1'b0;
    mem_wstrb = 4'h0;
    n = 0;
    do begin
      @(negedge clock);
      n++;
      if (n == 1 && (kind == kind_miss || kind == kind_direct)) begin
        compare_value(32'(dmem_valid), 1, "dmem_valid after mem_valid");
      end
    end while (!mem_ready);
    got_rdata = mem_rdata;
    if (kind == kind_hit) begin
      compare_value(n, 1, "hit latency");
    end
    if (kind == kind_miss || kind == kind_direct) begin
      compare_value(32'(dmem_ready), 1, "dmem_ready with mem_ready");
    end
    if (check_rdata) begin
      compare_value(got_rdata, exp_rdata, "mem_rdata");
    end
    #1; // Monitor has pushed the last request.
    compare_value(tx_addr.size(), exp_addr.size(), "dmem request count");
    for (int i = 0; i < exp_addr.size() && i < tx_addr.size(); i++) begin
      compare_value(tx_addr[i], exp_addr[i], "dmem_addr");
      compare_value(tx_data[i], exp_data[i], "dmem_wdata");
      compare_value(32'(tx_strb[i]), 32'(exp_strb[i]), "dmem_wstrb");
    end
  endtask

  // ====================
  // Stimulus
  // ====================
  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] addr;
    int fences_left;
    void'($urandom(13648));
    fences_left = max_random_fences;
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_fence = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = backing_i.words[i]; // Preset contents.
    end
    repeat (4) begin
      @(negedge clock);
      compare_value(32'(mem_ready), 0, "mem_ready after reset");
      compare_value(32'(dmem_valid), 0, "dmem_valid after reset");
    end

    // Outside the window, unaligned.
    run_op(1'b0, 32'h0000_0a43, 32'h0, 4'h0);
    run_op(1'b0, 32'h0000_3122, 32'hcafe_f00d, 4'b0110);
    run_op(1'b0, 32'h0000_2120, 32'h0, 4'h0);
    // Store miss, then a hit load.
    run_op(1'b0, 32'h0000_1040, 32'h1122_3344, 4'b0011);
    run_op(1'b0, 32'h0000_1040, 32'h0, 4'h0);
    run_op(1'b0, 32'h0000_1040, 32'haabb_ccdd, 4'b1000);
    run_op(1'b0, 32'h0000_1041, 32'h5566_7788, 4'b0100);
    run_op(1'b0, 32'h0000_1040, 32'h0, 4'h0);
    run_op(1'b0, 32'h0000_1140, 32'h0bad_beef, 4'b1111); // Other tag, same slot.
    run_op(1'b0, 32'h0000_1ffc, 32'h8765_4321, 4'b1111);
    run_op(1'b1, 32'h0, 32'h0, 4'h0);
    run_op(1'b0, 32'h0000_1040, 32'h0, 4'h0);
    run_op(1'b0, 32'h0000_1ffc, 32'h0, 4'h0);

    // Random mix over four aliasing tags.
    for (int k = 0; k < num_random; k++) begin
      r = $urandom;
      a = $urandom;
      if (r[4:0] == 5'd0 && fences_left > 0) begin
        fences_left--;
        run_op(1'b1, 32'h0, 32'h0, 4'h0);
      end else begin
        if (r[7:5] == 3'd0) begin
          addr = 32'h0000_3000 | {20'd0, a[11:0]};
        end else begin
          addr = `DTIM_BASE_ADDR | {22'd0, a[9:8], 2'b00, a[5:0]};
        end
        run_op(1'b0, addr, $urandom, r[8] ? 4'($urandom) : 4'h0);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/dtim_backing_mem.sv ====
`timescale 1ns/1ps

module dtim_backing_mem (
  input logic clock,
  input logic reset,
  input logic dmem_valid,
  input logic [31:0] dmem_addr,
  input logic [31:0] dmem_wdata,
  input logic [3:0] dmem_wstrb,
  output logic [31:0] dmem_rdata,
  output logic dmem_ready
);

  logic [31:0] words [1024]; // 4 KB word store.
  logic busy;
  logic [1:0] wait_count;
  logic [9:0] index;

  assign index = dmem_addr[11:2];

  always @(posedge clock) begin
    logic [1:0] delay;
    logic [31:0] merged;
    if (!reset) begin
      busy <= 1'b0;
      wait_count <= '0;
      dmem_ready <= 1'b0;
      dmem_rdata <= '0;
      for (int i = 0; i < 1024; i++) begin
        words[i] <= $urandom;
      end
    end else if (dmem_ready) begin
      dmem_ready <= 1'b0; // One-cycle pulse.
    end else if (dmem_valid) begin
      delay = busy ? wait_count : 2'($urandom);
      if (delay == 2'd0) begin
        merged = words[index];
        for (int b = 0; b < 4; b++) begin
          if (dmem_wstrb[b]) begin
            merged[8*b +: 8] = dmem_wdata[8*b +: 8];
          end
        end
        busy <= 1'b0;
        dmem_ready <= 1'b1;
        dmem_rdata <= words[index]; // Old word, also on writes.
        words[index] <= merged;
      end else begin
        busy <= 1'b1;
        wait_count <= delay - 2'd1;
      end
    end
  end

endmodule

// ==== design/dtim.sv ====
`timescale 1ns/1ps

module dtim (
  input logic clock,
  input logic reset,
  // Core side.
  input logic mem_valid,
  input logic mem_fence,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata,
  input logic [3:0] mem_wstrb,
  output logic [31:0] mem_rdata,
  output logic mem_ready,
  // Backing memory side.
  output logic dmem_valid,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic [3:0] dmem_wstrb,
  input logic [31:0] dmem_rdata,
  input logic dmem_ready
);

  dtim_front_if front_if ();
  dtim_bank_if bank_if ();

  dtim_front front_i (
    .clock (clock),
    .reset (reset),
    .mem_valid (mem_valid),
    .mem_fence (mem_fence),
    .mem_addr (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .front (front_if.front)
  );

  dtim_ctrl ctrl_i (
    .clock (clock),
    .reset (reset),
    .front (front_if.ctrl),
    .bank (bank_if.ctrl),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .dmem_valid (dmem_valid),
    .dmem_addr (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready)
  );

  dtim_bank_array banks_i (
    .clock (clock),
    .bank (bank_if.banks)
  );

endmodule

// ==== design/dtim_ctrl.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_ctrl import dtim_pkg::*; (
  input logic clock,
  input logic reset,
  dtim_front_if.ctrl front,
  dtim_bank_if.ctrl bank,
  output logic [31:0] mem_rdata,
  output logic mem_ready,
  output logic dmem_valid,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic [3:0] dmem_wstrb,
  input logic [31:0] dmem_rdata,
  input logic dmem_ready
);

  dtim_state_e state_q, state_d;
  logic [`DTIM_SET_BITS-1:0] set_q, set_d; // Fence walk position.
  logic [`DTIM_WAY_BITS-1:0] way_q, way_d;
  logic clear_q, clear_d;

  // Saved request for miss and direct.
  dtim_addr_u addr_q;
  logic [31:0] data_q;
  logic [3:0] strb_q;

  logic in_window;
  logic tag_match;
  logic go_miss;
  logic go_direct;
  logic launch;
  dtim_addr_u launch_addr;
  logic wb_needed;
  logic advance;
  logic [31:0] wb_addr;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // ====================
  // Classification
  // ====================
  assign in_window = (front.addr.word >= `DTIM_BASE_ADDR) &&
                     (front.addr.word < `DTIM_TOP_ADDR);
  assign tag_match = bank.rentry.tag == front.addr.fields.tag;
  assign go_miss = in_window && !bank.rentry.lock;
  assign go_direct = !in_window || (bank.rentry.lock && !tag_match);
  assign launch = (state_q == state_hit) && front.enable && !front.fence &&
                  (go_miss || go_direct);
  assign launch_addr = {front.addr.word[31:2], 2'b00};

  // Fence write-back of the slot on rentry.
  assign wb_needed = bank.rentry.lock && bank.rentry.dirty;
  assign advance = !wb_needed || dmem_ready;
  assign wb_addr = {bank.rentry.tag, set_q, way_q, 2'b00};

  always_comb begin
    state_d = state_q;
    set_d = set_q;
    way_d = way_q;
    clear_d = 1'b0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    bank.raddr = front.next_set;
    bank.rway = front.next_way;
    bank.wen = 1'b0;
    bank.waddr = front.addr.fields.set;
    bank.wway = front.addr.fields.way;
    bank.wentry = '0;
    case (state_q)
      state_hit: begin
        if (front.enable) begin
          if (front.fence) begin
            state_d = state_fence;
            set_d = '0;
            way_d = '0;
          end else if (go_miss) begin
            state_d = state_miss;
          end else if (go_direct) begin
            state_d = state_direct;
          end else begin
            mem_ready = 1'b1;
            mem_rdata = front.wren ? '0 : bank.rentry.data; // Stores return zero.
            bank.wen = front.wren;
            bank.wentry = '{lock: 1'b1, dirty: 1'b1, tag: front.addr.fields.tag,
                            data: merge_bytes(bank.rentry.data, front.data, front.strb)};
          end
        end
      end
      state_miss: begin
        if (dmem_ready) begin
          state_d = state_hit;
          mem_ready = 1'b1;
          mem_rdata = dmem_rdata;
          bank.wen = |strb_q; // Only stores allocate.
          bank.waddr = addr_q.fields.set;
          bank.wway = addr_q.fields.way;
          bank.wentry = '{lock: 1'b1, dirty: 1'b1, tag: addr_q.fields.tag,
                          data: merge_bytes(dmem_rdata, data_q, strb_q)};
        end
      end
      state_direct: begin
        if (dmem_ready) begin
          state_d = state_hit;
          mem_ready = 1'b1;
          mem_rdata = dmem_rdata;
        end
      end
      state_fence: begin
        if (advance) begin
          way_d = way_q + 1'b1;
          if (&way_q) begin
            set_d = set_q + 1'b1;
            clear_d = 1'b1;
            if (&set_q) begin
              state_d = state_hit;
              mem_ready = 1'b1;
            end
          end
        end
      end
    endcase
    // Walk reads the next slot, or holds it while stalled.
    if (state_d == state_fence) begin
      bank.raddr = set_d;
      bank.rway = way_d;
    end
    if (clear_q) begin
      bank.waddr = set_q - 1'b1; // Set just finished.
    end
  end

  assign bank.clear = clear_q;

  // ====================
  // Backing port
  // ====================
  always_comb begin
    dmem_valid = 1'b1;
    dmem_addr = addr_q.word;
    dmem_wdata = (|strb_q) ? data_q : '0;
    dmem_wstrb = strb_q;
    case (state_q)
      state_hit: begin
        dmem_valid = launch;
        dmem_addr = launch_addr.word;
        dmem_wdata = (go_miss || !front.wren) ? '0 : front.data;
        dmem_wstrb = go_miss ? '0 : front.strb;
      end
      state_miss: begin
        dmem_wdata = '0; // Miss fetch is a read.
        dmem_wstrb = '0;
      end
      state_fence: begin
        dmem_valid = wb_needed;
        dmem_addr = wb_addr;
        dmem_wdata = bank.rentry.data;
        dmem_wstrb = 4'hf;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= state_hit;
      set_q <= '0;
      way_q <= '0;
      clear_q <= 1'b0;
    end else begin
      state_q <= state_d;
      set_q <= set_d;
      way_q <= way_d;
      clear_q <= clear_d;
    end
  end

  always_ff @(posedge clock) begin
    if (launch) begin
      addr_q <= launch_addr;
      data_q <= front.data;
      strb_q <= front.strb;
    end
  end

endmodule

// ==== design/dtim_front.sv ====
`timescale 1ns/1ps

module dtim_front import dtim_pkg::*; (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input logic mem_fence,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata,
  input logic [3:0] mem_wstrb,
  dtim_front_if.front front
);

  dtim_addr_u next_addr;

  logic enable_q;
  logic fence_q;
  logic wren_q;
  dtim_addr_u addr_q;
  logic [31:0] data_q;
  logic [3:0] strb_q;

  // Request capture.
  always_ff @(posedge clock) begin
    if (!reset) begin
      enable_q <= 1'b0;
      fence_q <= 1'b0;
      wren_q <= 1'b0;
      addr_q <= '0;
      data_q <= '0;
      strb_q <= '0;
    end else begin
      enable_q <= mem_valid; // High for one cycle.
      if (mem_valid) begin
        fence_q <= mem_fence;
        wren_q <= |mem_wstrb;
        addr_q <= mem_addr;
        data_q <= mem_wdata;
        strb_q <= mem_wstrb;
      end
    end
  end

  // Bank read starts while the request is being captured.
  assign next_addr = mem_addr;
  assign front.next_set = next_addr.fields.set;
  assign front.next_way = next_addr.fields.way;

  assign front.enable = enable_q;
  assign front.fence = fence_q;
  assign front.wren = wren_q;
  assign front.addr = addr_q;
  assign front.data = data_q;
  assign front.strb = strb_q;

endmodule

// ==== design/dtim_bank_array.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_bank_array import dtim_pkg::*; (
  input logic clock,
  dtim_bank_if.banks bank
);

  dtim_entry_t rentry_bank [`DTIM_WAYS];
  dtim_entry_t wentry_w;
  logic [`DTIM_WAY_BITS-1:0] rway_q;

  // Clear overrides any normal write.
  assign wentry_w = bank.clear ? '0 : bank.wentry;

  // Way select lines up with the registered read address.
  always_ff @(posedge clock) begin
    rway_q <= bank.rway;
  end

  for (genvar i = 0; i < `DTIM_WAYS; i++) begin : g_bank
    logic wen_i;

    assign wen_i = bank.clear || (bank.wen && (bank.wway == i));

    dtim_ram ram_i (
      .clock (clock),
      .waddr (bank.waddr),
      .wen (wen_i),
      .wentry (wentry_w),
      .raddr (bank.raddr), // Same set in all banks.
      .rentry (rentry_bank[i])
    );
  end

  assign bank.rentry = rentry_bank[rway_q];

endmodule

// ==== design/dtim_ram.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_ram import dtim_pkg::*; (
  input logic clock,
  input logic [`DTIM_SET_BITS-1:0] waddr,
  input logic wen,
  input dtim_entry_t wentry,
  input logic [`DTIM_SET_BITS-1:0] raddr,
  output dtim_entry_t rentry
);

  dtim_entry_t mem_array [`DTIM_SETS] = '{default: '0};

  logic [`DTIM_SET_BITS-1:0] raddr_q;

  always_ff @(posedge clock) begin
    if (wen) begin
      mem_array[waddr] <= wentry;
    end
    raddr_q <= raddr;
  end

  // Data follows raddr by one cycle.
  assign rentry = mem_array[raddr_q];

endmodule

// ==== design/dtim_bank_if.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

interface dtim_bank_if import dtim_pkg::*; ();

  // Read side.
  logic [`DTIM_SET_BITS-1:0] raddr;
  logic [`DTIM_WAY_BITS-1:0] rway;
  dtim_entry_t rentry;

  // Write side.
  logic wen;
  logic [`DTIM_SET_BITS-1:0] waddr;
  logic [`DTIM_WAY_BITS-1:0] wway;
  dtim_entry_t wentry;
  logic clear; // Zeroes set waddr in all banks.

  modport ctrl (
    output raddr, rway, wen, waddr, wway, wentry, clear,
    input rentry
  );

  modport banks (
    input raddr, rway, wen, waddr, wway, wentry, clear,
    output rentry
  );

endinterface

// ==== design/dtim_front_if.sv ====
`timescale 1ns/1ps
`include "dtim_macros.svh"

interface dtim_front_if import dtim_pkg::*; ();

  logic enable; // One cycle per captured request.
  logic fence;
  logic wren;
  dtim_addr_u addr;
  logic [31:0] data;
  logic [3:0] strb;

  // Slot of the request arriving this cycle.
  logic [`DTIM_SET_BITS-1:0] next_set;
  logic [`DTIM_WAY_BITS-1:0] next_way;

  modport front (
    output enable, fence, wren, addr, data, strb,
    output next_set, next_way
  );

  modport ctrl (
    input enable, fence, wren, addr, data, strb,
    input next_set, next_way
  );

endinterface

// ==== design/dtim_pkg.sv ====
`include "dtim_macros.svh"

package dtim_pkg;

  // Word address split into slot coordinates.
  typedef struct packed {
    logic [`DTIM_TAG_BITS-1:0] tag;
    logic [`DTIM_SET_BITS-1:0] set;
    logic [`DTIM_WAY_BITS-1:0] way;
    logic [1:0] offset; // Byte within the word.
  } dtim_addr_fields_t;

  typedef union packed {
    logic [31:0] word;
    dtim_addr_fields_t fields;
  } dtim_addr_u;

  // All zero means free.
  typedef struct packed {
    logic lock;
    logic dirty;
    logic [`DTIM_TAG_BITS-1:0] tag;
    logic [31:0] data;
  } dtim_entry_t;

  typedef enum logic [1:0] {
    state_hit,
    state_miss,
    state_direct,
    state_fence
  } dtim_state_e;

endpackage

// ==== include/dtim_macros.svh ====
`ifndef DTIM_MACROS_SVH
`define DTIM_MACROS_SVH

// ====================
// Geometry
// ====================
`define DTIM_SETS 16 // Entries per bank.
`define DTIM_WAYS 4 // Banks.
`define DTIM_SET_BITS $clog2(`DTIM_SETS)
`define DTIM_WAY_BITS $clog2(`DTIM_WAYS)
`define DTIM_TAG_BITS (32 - `DTIM_SET_BITS - `DTIM_WAY_BITS - 2)

// ====================
// Address window
// ====================
// 1024 words, so slots alias.
`define DTIM_BASE_ADDR 32'h0000_1000
`define DTIM_TOP_ADDR 32'h0000_2000 // First byte past the window.

`endif
